// ==== source/isa_pkg.sv ====
// ========================================
// MIPS32 integer subset, encodings only
// word access only, no branch/jump/hi-lo
// nop is the all-zero word (sll r0,r0,0)
// ========================================
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef struct packed {
        logic [5:0] op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    // same 32 bits, read as either format
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam word_t NOP_WORD = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== source/pipe_pkg.sv ====
// ========================================
// pipeline register layouts
// a bubble is any entry with all of
// reg_write/mem_read/mem_write low
// ========================================
`default_nettype none

package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t instr;     // NOP_WORD when empty
    } if_id_t;

    typedef struct packed {
        alu_op_t            alu_op;
        isa_pkg::word_t     op_a;
        isa_pkg::word_t     op_b;        // register or extended immediate
        isa_pkg::word_t     store_data;
        isa_pkg::reg_addr_t dest;
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
    } id_ex_t;

    typedef struct packed {
        isa_pkg::word_t     result;      // also the ram address
        isa_pkg::word_t     store_data;
        isa_pkg::reg_addr_t dest;
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
    } ex_mem_t;

    // regfile write port, also a forwarding source
    typedef struct packed {
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     data;
        logic               reg_write;
    } wb_t;

endpackage

`default_nettype wire

// ==== source/fetch_stage.sv ====
// ========================================
// pc and fetch/decode register
// rom answers in the same cycle
// ========================================
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             stall_i,
    input  isa_pkg::word_t   rom_data_i,
    output isa_pkg::word_t   rom_addr_o,
    output logic             rom_ce_o,
    output pipe_pkg::if_id_t if_id_o
);

    isa_pkg::word_t pc_q;
    logic           ce_q;

    assign rom_addr_o = pc_q;
    assign rom_ce_o   = ce_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ce_q          <= 1'b0;
            pc_q          <= isa_pkg::RESET_PC;
            if_id_o.pc    <= isa_pkg::RESET_PC;
            if_id_o.instr <= isa_pkg::NOP_WORD;
        end else begin
            ce_q <= 1'b1;
            if (!stall_i) begin // stall holds pc and if_id
                if (ce_q) begin
                    pc_q <= pc_q + 32'd4;
                end
                if_id_o.pc    <= pc_q;
                if_id_o.instr <= ce_q ? rom_data_i : isa_pkg::NOP_WORD;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
// ========================================
// 32 x 32 register file, two read ports
// r0 reads zero, writes pass through
// ========================================
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic               clk_i,
    input  logic               reset_i,
    input  pipe_pkg::wb_t      wb_i,
    input  isa_pkg::reg_addr_t raddr_a_i,
    input  isa_pkg::reg_addr_t raddr_b_i,
    output isa_pkg::word_t     rdata_a_o,
    output isa_pkg::word_t     rdata_b_o
);

    isa_pkg::word_t regs [32];

    function automatic isa_pkg::word_t read_port(input isa_pkg::reg_addr_t addr,
                                                 input pipe_pkg::wb_t      wb,
                                                 input isa_pkg::word_t     stored);
        if (addr == '0) begin
            return '0;
        end
        if (wb.reg_write && wb.dest == addr) begin
            return wb.data; // writeback stage bypass
        end
        return stored;
    endfunction

    assign rdata_a_o = read_port(raddr_a_i, wb_i, regs[raddr_a_i]);
    assign rdata_b_o = read_port(raddr_b_i, wb_i, regs[raddr_b_i]);

    always_ff @(posedge clk_i) begin
        if (!reset_i && wb_i.reg_write && wb_i.dest != '0) begin
            regs[wb_i.dest] <= wb_i.data;
        end
    end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
// ========================================
// decode, operand forwarding, load-use
// stall; unknown opcodes become a nop
// ========================================
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic               clk_i,
    input  logic               reset_i,
    input  pipe_pkg::if_id_t   if_id_i,
    input  isa_pkg::word_t     rdata_a_i,
    input  isa_pkg::word_t     rdata_b_i,
    input  pipe_pkg::wb_t      ex_fwd_i,
    input  logic               ex_load_i,
    input  pipe_pkg::wb_t      mem_fwd_i,
    output isa_pkg::reg_addr_t raddr_a_o,
    output isa_pkg::reg_addr_t raddr_b_o,
    output logic               stall_o,
    output pipe_pkg::id_ex_t   id_ex_o
);

    isa_pkg::instr_t  instr;
    isa_pkg::word_t   imm_sext;
    isa_pkg::word_t   imm_zext;
    isa_pkg::word_t   src_a;
    isa_pkg::word_t   src_b;
    pipe_pkg::id_ex_t id_ex_d;
    logic             read_a;
    logic             read_b;

    // execute beats memory beats regfile
    function automatic isa_pkg::word_t pick(input isa_pkg::reg_addr_t addr,
                                            input isa_pkg::word_t     rdata,
                                            input pipe_pkg::wb_t      ex,
                                            input pipe_pkg::wb_t      mem);
        if (addr != '0 && ex.reg_write && ex.dest == addr) begin
            return ex.data;
        end
        if (addr != '0 && mem.reg_write && mem.dest == addr) begin
            return mem.data;
        end
        return rdata;
    endfunction

    assign instr     = if_id_i.instr;
    assign raddr_a_o = instr.r.rs;
    assign raddr_b_o = instr.r.rt;
    assign imm_sext  = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext  = {16'h0000, instr.i.imm};
    assign src_a     = pick(instr.r.rs, rdata_a_i, ex_fwd_i, mem_fwd_i);
    assign src_b     = pick(instr.r.rt, rdata_b_i, ex_fwd_i, mem_fwd_i);

    // load data only exists from the memory stage on
    assign stall_o = ex_load_i && ex_fwd_i.dest != '0 &&
                     ((read_a && ex_fwd_i.dest == instr.r.rs) ||
                      (read_b && ex_fwd_i.dest == instr.r.rt));

    always_comb begin
        id_ex_d            = '0;
        id_ex_d.op_a       = src_a;
        id_ex_d.op_b       = imm_sext;
        id_ex_d.store_data = src_b;
        id_ex_d.dest       = instr.i.rt;
        read_a             = 1'b1;
        read_b             = 1'b0;
        case (instr.i.op)
            isa_pkg::OP_SPECIAL: begin
                id_ex_d.op_b      = src_b;
                id_ex_d.dest      = instr.r.rd;
                id_ex_d.reg_write = 1'b1;
                read_b            = 1'b1;
                case (instr.r.funct)
                    isa_pkg::FN_ADDU: id_ex_d.alu_op = pipe_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: id_ex_d.alu_op = pipe_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  id_ex_d.alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::FN_OR:   id_ex_d.alu_op = pipe_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  id_ex_d.alu_op = pipe_pkg::ALU_XOR;
                    isa_pkg::FN_NOR:  id_ex_d.alu_op = pipe_pkg::ALU_NOR;
                    isa_pkg::FN_SLT:  id_ex_d.alu_op = pipe_pkg::ALU_SLT;
                    default: begin // sll nop lands here too
                        id_ex_d.reg_write = 1'b0;
                        read_a            = 1'b0;
                        read_b            = 1'b0;
                    end
                endcase
            end
            isa_pkg::OP_ADDIU: id_ex_d.reg_write = 1'b1;
            isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI: begin
                id_ex_d.op_b      = imm_zext;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_op    = (instr.i.op == isa_pkg::OP_ANDI) ? pipe_pkg::ALU_AND :
                                    (instr.i.op == isa_pkg::OP_ORI)  ? pipe_pkg::ALU_OR :
                                                                       pipe_pkg::ALU_XOR;
            end
            isa_pkg::OP_LUI: begin
                id_ex_d.alu_op    = pipe_pkg::ALU_LUI;
                id_ex_d.op_b      = imm_zext;
                id_ex_d.reg_write = 1'b1;
                read_a            = 1'b0; // rs field unused
            end
            isa_pkg::OP_LW: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.mem_read  = 1'b1;
            end
            isa_pkg::OP_SW: begin
                id_ex_d.mem_write = 1'b1;
                read_b            = 1'b1;
            end
            default: read_a = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || stall_o) begin // bubble
            id_ex_o.reg_write <= 1'b0;
            id_ex_o.mem_read  <= 1'b0;
            id_ex_o.mem_write <= 1'b0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
// ========================================
// ALU and execute/memory register
// slt is signed, no overflow traps
// ========================================
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic              clk_i,
    input  logic              reset_i,
    input  pipe_pkg::id_ex_t  id_ex_i,
    output pipe_pkg::wb_t     ex_fwd_o,
    output logic              ex_load_o,
    output pipe_pkg::ex_mem_t ex_mem_o
);

    isa_pkg::word_t result;

    always_comb begin
        case (id_ex_i.alu_op)
            pipe_pkg::ALU_ADD: result = id_ex_i.op_a + id_ex_i.op_b;
            pipe_pkg::ALU_SUB: result = id_ex_i.op_a - id_ex_i.op_b;
            pipe_pkg::ALU_AND: result = id_ex_i.op_a & id_ex_i.op_b;
            pipe_pkg::ALU_OR:  result = id_ex_i.op_a | id_ex_i.op_b;
            pipe_pkg::ALU_XOR: result = id_ex_i.op_a ^ id_ex_i.op_b;
            pipe_pkg::ALU_NOR: result = ~(id_ex_i.op_a | id_ex_i.op_b);
            pipe_pkg::ALU_SLT: result = {31'b0, $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
            pipe_pkg::ALU_LUI: result = {id_ex_i.op_b[15:0], 16'h0000};
            default:           result = '0;
        endcase
    end

    // for a load this is the address, decode stalls on it instead
    assign ex_fwd_o = '{dest: id_ex_i.dest, data: result, reg_write: id_ex_i.reg_write};
    assign ex_load_o = id_ex_i.mem_read;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ex_mem_o.reg_write <= 1'b0;
            ex_mem_o.mem_read  <= 1'b0;
            ex_mem_o.mem_write <= 1'b0;
        end else begin
            ex_mem_o.result     <= result;
            ex_mem_o.store_data <= id_ex_i.store_data;
            ex_mem_o.dest       <= id_ex_i.dest;
            ex_mem_o.reg_write  <= id_ex_i.reg_write;
            ex_mem_o.mem_read   <= id_ex_i.mem_read;
            ex_mem_o.mem_write  <= id_ex_i.mem_write;
        end
    end

endmodule

`default_nettype wire

// ==== source/memory_stage.sv ====
// ========================================
// data ram access, full words only
// ram read data valid in the same cycle
// ========================================
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic              clk_i,
    input  logic              reset_i,
    input  pipe_pkg::ex_mem_t ex_mem_i,
    input  isa_pkg::word_t    ram_data_i,
    output isa_pkg::word_t    ram_addr_o,
    output isa_pkg::word_t    ram_data_o,
    output logic              ram_we_o,
    output logic              ram_ce_o,
    output pipe_pkg::wb_t     mem_fwd_o,
    output pipe_pkg::wb_t     wb_o
);

    isa_pkg::word_t wb_data;

    assign ram_ce_o   = ex_mem_i.mem_read || ex_mem_i.mem_write;
    assign ram_we_o   = ex_mem_i.mem_write; // written at the next edge
    assign ram_addr_o = ex_mem_i.result;
    assign ram_data_o = ex_mem_i.store_data;

    assign wb_data   = ex_mem_i.mem_read ? ram_data_i : ex_mem_i.result;
    assign mem_fwd_o = '{dest: ex_mem_i.dest, data: wb_data, reg_write: ex_mem_i.reg_write};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_o.reg_write <= 1'b0;
        end else begin
            wb_o <= mem_fwd_o;
        end
    end

endmodule

`default_nettype wire

// ==== source/mips_core.sv ====
// ========================================
// five-stage MIPS integer core
// rom and ram are combinational reads
// ========================================
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic           clk_i,
    input  logic           reset_i,
    input  isa_pkg::word_t rom_data_i,
    input  isa_pkg::word_t ram_data_i,
    output isa_pkg::word_t rom_addr_o,
    output logic           rom_ce_o,
    output isa_pkg::word_t ram_addr_o,
    output isa_pkg::word_t ram_data_o,
    output logic           ram_we_o,
    output logic           ram_ce_o
);

    pipe_pkg::if_id_t   if_id;
    pipe_pkg::id_ex_t   id_ex;
    pipe_pkg::ex_mem_t  ex_mem;
    pipe_pkg::wb_t      wb;
    pipe_pkg::wb_t      ex_fwd;      // back to decode
    pipe_pkg::wb_t      mem_fwd;
    logic               ex_load;
    logic               stall;
    isa_pkg::reg_addr_t raddr_a;
    isa_pkg::reg_addr_t raddr_b;
    isa_pkg::word_t     rdata_a;
    isa_pkg::word_t     rdata_b;

    fetch_stage fetch_stage_inst0 (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .stall_i    (stall),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .if_id_o    (if_id)
    );

    decode_stage decode_stage_inst0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .if_id_i   (if_id),
        .rdata_a_i (rdata_a),
        .rdata_b_i (rdata_b),
        .ex_fwd_i  (ex_fwd),
        .ex_load_i (ex_load),
        .mem_fwd_i (mem_fwd),
        .raddr_a_o (raddr_a),
        .raddr_b_o (raddr_b),
        .stall_o   (stall),
        .id_ex_o   (id_ex)
    );

    register_file register_file_inst0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wb_i      (wb),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    execute_stage execute_stage_inst0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .id_ex_i   (id_ex),
        .ex_fwd_o  (ex_fwd),
        .ex_load_o (ex_load),
        .ex_mem_o  (ex_mem)
    );

    memory_stage memory_stage_inst0 (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .ex_mem_i   (ex_mem),
        .ram_data_i (ram_data_i),
        .ram_addr_o (ram_addr_o),
        .ram_data_o (ram_data_o),
        .ram_we_o   (ram_we_o),
        .ram_ce_o   (ram_ce_o),
        .mem_fwd_o  (mem_fwd),
        .wb_o       (wb)
    );

endmodule

`default_nettype wire

// ==== test/tb_mips_core.sv ====
// ========================================
// directed tests for the five-stage core
// rom/ram are 64-word combinational models
// registers are not reset between tests
// ========================================
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam int          TIMEOUT_CYCLES = 400; // programs, resets, 20 spare per test
    localparam logic [31:0] RAND_SEED      = 32'h05db_fa8e;

    logic           clk_i;
    logic           reset_i;
    isa_pkg::word_t rom_data_i;
    isa_pkg::word_t ram_data_i;
    isa_pkg::word_t rom_addr_o;
    logic           rom_ce_o;
    isa_pkg::word_t ram_addr_o;
    isa_pkg::word_t ram_data_o;
    logic           ram_we_o;
    logic           ram_ce_o;

    isa_pkg::word_t rom [64];
    isa_pkg::word_t ram [64];
    isa_pkg::word_t mem_model [64];
    isa_pkg::word_t reg_model [32]; // architectural state per the ISA rules
    isa_pkg::word_t exp_addr [$];
    isa_pkg::word_t exp_data [$];
    isa_pkg::word_t st_addr [$];
    isa_pkg::word_t st_data [$];
    int             prog_len;
    int             cycle_count = 0;

    mips_core uut (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rom_data_i (rom_data_i),
        .ram_data_i (ram_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .ram_addr_o (ram_addr_o),
        .ram_data_o (ram_data_o),
        .ram_we_o   (ram_we_o),
        .ram_ce_o   (ram_ce_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // nops outside the rom window
    assign rom_data_i = (rom_addr_o[31:8] == 24'h0) ? rom[rom_addr_o[7:2]] : isa_pkg::NOP_WORD;
    assign ram_data_i = ram_ce_o ? ram[ram_addr_o[7:2]] : '0; // reads only while enabled

    always @(posedge clk_i) begin
        if (ram_ce_o && ram_we_o) begin
            ram[ram_addr_o[7:2]] = ram_data_o;
        end
    end

    always @(negedge clk_i) begin
        if (!reset_i && ram_ce_o && ram_we_o) begin
            st_addr.push_back(ram_addr_o);
            st_data.push_back(ram_data_o);
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic isa_pkg::word_t fill_word(input int idx);
        return 32'hc0de_0000 | 32'(idx * 4); // byte address in the low bits
    endfunction

    function automatic isa_pkg::word_t sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic isa_pkg::word_t enc_r(input logic [5:0] funct, input isa_pkg::reg_addr_t rd,
                                             input isa_pkg::reg_addr_t rs,
                                             input isa_pkg::reg_addr_t rt);
        return {isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic isa_pkg::word_t enc_i(input logic [5:0] op, input isa_pkg::reg_addr_t rt,
                                             input isa_pkg::reg_addr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic isa_pkg::word_t ref_r(input logic [5:0] funct, input isa_pkg::word_t a,
                                             input isa_pkg::word_t b);
        case (funct)
            isa_pkg::FN_ADDU: return a + b;
            isa_pkg::FN_SUBU: return a - b;
            isa_pkg::FN_AND:  return a & b;
            isa_pkg::FN_OR:   return a | b;
            isa_pkg::FN_XOR:  return a ^ b;
            isa_pkg::FN_NOR:  return ~(a | b);
            isa_pkg::FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:          return '0;
        endcase
    endfunction

    function automatic isa_pkg::word_t ref_imm(input logic [5:0] op, input isa_pkg::word_t a,
                                               input logic [15:0] imm);
        case (op)
            isa_pkg::OP_ADDIU: return a + sext16(imm);
            isa_pkg::OP_ANDI:  return a & {16'h0000, imm};
            isa_pkg::OP_ORI:   return a | {16'h0000, imm};
            isa_pkg::OP_XORI:  return a ^ {16'h0000, imm};
            isa_pkg::OP_LUI:   return {imm, 16'h0000};
            default:           return '0;
        endcase
    endfunction

    task automatic check_word(input isa_pkg::word_t expected, input isa_pkg::word_t actual,
                              input string msg);
        if (actual !== expected) begin
            $display("** Error at %0t: %s, expected %h got %h", $time, msg, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "data word mismatch");
        end
    endtask

    task automatic check_addr(input isa_pkg::word_t expected, input isa_pkg::word_t actual,
                              input string msg);
        if (actual !== expected) begin
            $display("** Error at %0t: %s, expected %h got %h", $time, msg, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_flag(input logic expected, input logic actual, input string msg);
        if (actual !== expected) begin
            $display("** Error at %0t: %s, expected %b got %b", $time, msg, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "control flag mismatch");
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < 64; i++) begin
            rom[i] = isa_pkg::NOP_WORD;
        end
        prog_len = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic emit(input isa_pkg::word_t word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic emit_r(input logic [5:0] funct, input isa_pkg::reg_addr_t rd,
                          input isa_pkg::reg_addr_t rs, input isa_pkg::reg_addr_t rt);
        emit(enc_r(funct, rd, rs, rt));
        if (rd != 5'd0) begin
            reg_model[rd] = ref_r(funct, reg_model[rs], reg_model[rt]);
        end
    endtask

    task automatic emit_imm(input logic [5:0] op, input isa_pkg::reg_addr_t rt,
                            input isa_pkg::reg_addr_t rs, input logic [15:0] imm);
        emit(enc_i(op, rt, rs, imm));
        if (rt != 5'd0) begin
            reg_model[rt] = ref_imm(op, reg_model[rs], imm);
        end
    endtask

    task automatic load_const(input isa_pkg::reg_addr_t rt, input isa_pkg::word_t value);
        emit_imm(isa_pkg::OP_LUI, rt, 5'd0, value[31:16]);
        emit_imm(isa_pkg::OP_ORI, rt, rt, value[15:0]);
    endtask

    task automatic emit_sw(input isa_pkg::reg_addr_t rt, input isa_pkg::reg_addr_t base,
                           input logic [15:0] off);
        isa_pkg::word_t addr;
        addr = reg_model[base] + sext16(off);
        emit(enc_i(isa_pkg::OP_SW, rt, base, off));
        exp_addr.push_back(addr);
        exp_data.push_back(reg_model[rt]);
        mem_model[addr[7:2]] = reg_model[rt];
    endtask

    task automatic emit_lw(input isa_pkg::reg_addr_t rt, input isa_pkg::reg_addr_t base,
                           input logic [15:0] off);
        isa_pkg::word_t addr;
        addr = reg_model[base] + sext16(off);
        emit(enc_i(isa_pkg::OP_LW, rt, base, off));
        if (rt != 5'd0) begin
            reg_model[rt] = mem_model[addr[7:2]];
        end
    endtask

    // 10 cycles high, outputs checked once the flops have seen reset
    task automatic apply_reset();
        @(posedge clk_i);
        #1 reset_i = 1'b1;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk_i);
            if (i > 0) begin
                check_flag(1'b0, rom_ce_o, "rom_ce_o during reset");
                check_flag(1'b0, ram_ce_o, "ram_ce_o during reset");
                check_flag(1'b0, ram_we_o, "ram_we_o during reset");
                check_addr(isa_pkg::RESET_PC, rom_addr_o, "rom_addr_o during reset");
            end
        end
        @(posedge clk_i);
        #1 reset_i = 1'b0;
        st_addr.delete();
        st_data.delete();
    endtask

    task automatic run_and_compare(input string name);
        int n;
        n = exp_addr.size();
        while (st_addr.size() < n) begin
            @(posedge clk_i);
        end
        for (int i = 0; i < n; i++) begin
            check_addr(exp_addr[i], st_addr[i], {name, ": store address"});
            check_word(exp_data[i], st_data[i], {name, ": store data"});
        end
        $display("%s: %0d stores checked", name, n);
    endtask

    task automatic test_reset_fetch();
        int n;
        clear_program();
        apply_reset();
        n = 0;
        while (n < 4) begin
            @(negedge clk_i);
            if (rom_ce_o) begin
                check_addr(32'(n * 4), rom_addr_o, "fetch address after reset");
                n++;
            end
        end
        $display("reset_fetch: fetch order checked");
    endtask

    task automatic test_constants();
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t rnd;
        a   = $urandom();
        b   = $urandom();
        rnd = $urandom();
        clear_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit_imm(isa_pkg::OP_ADDIU, 5'd3, 5'd1, {1'b1, rnd[14:0]}); // always negative
        emit_imm(isa_pkg::OP_XORI, 5'd5, 5'd2, {1'b1, rnd[30:16]}); // top bit set
        emit_imm(isa_pkg::OP_ADDIU, 5'd4, 5'd0, 16'h0040);
        emit_sw(5'd1, 5'd4, 16'hfff0);
        emit_sw(5'd2, 5'd4, 16'hfff4);
        emit_sw(5'd3, 5'd4, 16'hfff8);
        emit_sw(5'd5, 5'd4, 16'h0000);
        apply_reset();
        run_and_compare("constants");
    endtask

    task automatic test_r_chain();
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        a = $urandom() | 32'h8000_0000;
        b = $urandom();
        clear_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit_r(isa_pkg::FN_ADDU, 5'd3, 5'd1, 5'd2);
        emit_r(isa_pkg::FN_SUBU, 5'd4, 5'd3, 5'd1);
        emit_r(isa_pkg::FN_AND, 5'd5, 5'd4, 5'd3);
        emit_r(isa_pkg::FN_OR, 5'd6, 5'd5, 5'd4);
        emit_r(isa_pkg::FN_XOR, 5'd7, 5'd6, 5'd5);
        emit_r(isa_pkg::FN_NOR, 5'd8, 5'd7, 5'd6);
        emit_r(isa_pkg::FN_SLT, 5'd9, 5'd8, 5'd7);
        emit_r(isa_pkg::FN_SLT, 5'd10, 5'd9, 5'd1); // r1 negative
        emit_r(isa_pkg::FN_SLT, 5'd11, 5'd1, 5'd9);
        for (int r = 3; r <= 11; r++) begin
            emit_sw(5'(r), 5'd0, 16'(32'h80 + (r - 3) * 4));
        end
        apply_reset();
        run_and_compare("r_chain");
    endtask

    task automatic test_load_use();
        clear_program();
        load_const(5'd1, $urandom());
        load_const(5'd2, $urandom());
        emit_imm(isa_pkg::OP_ADDIU, 5'd4, 5'd0, 16'h00c0);
        emit_sw(5'd1, 5'd4, 16'h0000);
        emit_lw(5'd3, 5'd4, 16'h0000);
        emit_r(isa_pkg::FN_ADDU, 5'd5, 5'd3, 5'd2); // stalls on rs
        emit_sw(5'd5, 5'd4, 16'h0004);
        emit_lw(5'd6, 5'd4, 16'h0000);
        emit_sw(5'd6, 5'd4, 16'h0008);              // stalls on rt
        apply_reset();
        run_and_compare("load_use");
    endtask

    task automatic test_zero_unknown();
        clear_program();
        load_const(5'd6, $urandom());
        emit_imm(isa_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h1234);
        emit_r(isa_pkg::FN_ADDU, 5'd0, 5'd6, 5'd6);
        emit_sw(5'd0, 5'd0, 16'h00d0);
        emit({6'h3f, 5'd0, 5'd6, 16'hffff});     // unknown opcode aimed at r6
        emit(enc_r(6'h3f, 5'd6, 5'd6, 5'd6));    // unknown funct
        emit_sw(5'd6, 5'd0, 16'h00d4);
        apply_reset();
        run_and_compare("zero_unknown");
    endtask

    initial begin
        reset_i = 1'b1;
        for (int i = 0; i < 64; i++) begin
            rom[i]       = isa_pkg::NOP_WORD;
            ram[i]       = fill_word(i);
            mem_model[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = '0;
        end
        void'($urandom(RAND_SEED));
        test_reset_fetch();
        test_constants();
        test_r_chain();
        test_load_use();
        test_zero_unknown();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/mips_core.sv
test/tb_mips_core.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_mips_core
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: run

run: $(SIM)
	./$(SIM)

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --top-module tb_mips_core -f verilog.f

clean:
	rm -rf obj_dir
